/* rv_frontend_defines.svh */
// Front end widths, boot address, register map width and counter width
`ifndef RV_FRONTEND_DEFINES_SVH
`define RV_FRONTEND_DEFINES_SVH

// Data and address width
`define XLEN 32

// PC value until software writes BOOT
`define BOOT_ADDR_RESET 32'h0000_0100

// Configuration port address width
`define CFG_AW 2

// Delivered and unknown record counters
`define CNT_W 16

`endif

/* isa_pkg.sv */
// RV32I mnemonic and class enums, flag and register index structs, decoded record
`default_nettype none

`include "rv_frontend_defines.svh"

package isa_pkg;

  typedef enum logic [5:0] {
    UNKNOWN,
    LUI, AUIPC,
    JAL, JALR,
    BEQ, BNE, BLT, BGE, BLTU, BGEU,
    LB, LH, LW, LBU, LHU,
    SB, SH, SW,
    ADDI, SLTI, SLTIU, XORI, ORI, ANDI,
    SLLI, SRLI, SRAI,
    ADD, SUB, SLL, SLT, SLTU, XOR, SRL, SRA, OR, AND,
    ECALL, EBREAK
  } instr_name_e;

  typedef enum logic [1:0] {
    LS,  // Loads and stores
    BR,  // Branches and jumps
    AL   // Arithmetic, logic, system
  } instr_type_e;

  typedef struct packed {
    logic writes;
    logic jumps;
    logic uses_imm;
  } instr_flags_t;

  typedef struct packed {
    logic [4:0] rd;
    logic [4:0] rs_1;
    logic [4:0] rs_2;
  } reg_idx_t;

  typedef struct packed {
    logic [`XLEN-1:0] address;
    logic [31:0]      instr;      // Raw word, funct bits for the back end
    logic [`XLEN-1:0] immediate;
    instr_name_e      instr_name;
    instr_type_e      instr_type;
    instr_flags_t     flags;
    reg_idx_t         regs;
  } instr_info_t;

endpackage

`default_nettype wire

/* frontend_pkg.sv */
// Fetch pair struct and configuration register map
`default_nettype none

`include "rv_frontend_defines.svh"

package frontend_pkg;

  // Word returned by the memory, tagged with its address
  typedef struct packed {
    logic [`XLEN-1:0] address;
    logic [31:0]      instr;
  } fetch_pair_t;

  typedef enum logic [`CFG_AW-1:0] {
    CTRL        = 2'd0,  // Bit 0 enables fetching
    BOOT        = 2'd1,  // Write restarts at this address
    DECODED_CNT = 2'd2,  // Read only
    UNKNOWN_CNT = 2'd3   // Read only
  } cfg_addr_e;

endpackage

`default_nettype wire

/* fetch_unit.sv */
// Fetch unit with program counter, memory request, response tagging and redirect
`timescale 1ns/1ps
`default_nettype none

`include "rv_frontend_defines.svh"

module fetch_unit import frontend_pkg::*; (
  input  logic             global_bus,
  input  logic             arst_n,
  input  logic             enable,
  input  logic             restart,
  input  logic [`XLEN-1:0] boot_addr,
  input  logic             redirect,
  input  logic [`XLEN-1:0] redirect_target,
  input  logic             stop,
  output logic             imem_req,
  output logic [`XLEN-1:0] imem_addr,
  input  logic [31:0]      imem_rdata,
  output logic             pair_valid,
  output fetch_pair_t      pair
);
  logic [`XLEN-1:0] pc;
  logic [`XLEN-1:0] req_addr;
  logic             req_pending;

  // No request in a cycle that overrides the PC
  assign imem_req  = enable && !stop && !redirect && !restart;
  assign imem_addr = pc;

  always_ff @(posedge global_bus or negedge arst_n) begin
    if (!arst_n) begin
      pc          <= `BOOT_ADDR_RESET;
      req_pending <= 1'b0;
    end else begin
      req_pending <= imem_req;
      if (restart) pc <= boot_addr;
      else if (redirect) pc <= redirect_target;
      else if (imem_req) pc <= pc + 32'd4;
    end
  end

  always_ff @(posedge global_bus) begin
    if (imem_req) req_addr <= pc;  // Address of the word in flight
  end

  assign pair_valid = req_pending;
  assign pair       = '{address: req_addr, instr: imem_rdata};

endmodule

`default_nettype wire

/* skid_buffer.sv */
// Two-entry ordered holding buffer with flush and stop toward the producer
`timescale 1ns/1ps
`default_nettype none

module skid_buffer #(
  parameter type payload_t = logic [31:0]
) (
  input  logic     global_bus,
  input  logic     arst_n,
  input  logic     flush,
  input  logic     in_valid,
  input  payload_t in_data,
  output logic     stop,
  output logic     out_valid,
  output payload_t out_data,
  input  logic     out_stop
);
  logic [1:0] count;
  payload_t   tail;
  logic       push;
  logic       pop;

  assign push      = in_valid;  // Always taken, stop already covers the item in flight
  assign pop       = out_valid && !out_stop;
  assign out_valid = (count != 2'd0);
  assign stop      = (count == 2'd2) || (out_valid && out_stop);

  always_ff @(posedge global_bus or negedge arst_n) begin
    if (!arst_n) begin
      count <= 2'd0;
    end else if (flush) begin
      count <= 2'd0;
    end else if (push && !pop) begin
      count <= count + 2'd1;
    end else if (pop && !push) begin
      count <= count - 2'd1;
    end
  end

  // Head sits in out_data, second entry in tail
  always_ff @(posedge global_bus) begin
    if (push && (count == 2'd0 || (pop && count == 2'd1))) out_data <= in_data;
    else if (pop) out_data <= tail;
    if (push && (count == 2'd2 || (!pop && count == 2'd1))) tail <= in_data;
  end

endmodule

`default_nettype wire

/* decoder.sv */
// Registered RV32I decoder producing the decoded record and its valid bit
`timescale 1ns/1ps
`default_nettype none

`include "rv_frontend_defines.svh"

module decoder import isa_pkg::*, frontend_pkg::*; (
  input  logic        global_bus,
  input  logic        arst_n,
  input  logic        in_valid,
  input  fetch_pair_t in_pair,
  input  logic        stop,
  input  logic        flush,
  output logic        info_valid,
  output instr_info_t info
);
  logic [31:0]      instr;
  logic [2:0]       funct3;
  logic [6:0]       funct7;
  logic [`XLEN-1:0] imm_d;
  reg_idx_t         regs_d;
  instr_name_e      name_d;
  instr_type_e      type_d;
  instr_flags_t     flags_d;

  assign instr  = in_pair.instr;
  assign funct3 = instr[14:12];
  assign funct7 = instr[31:25];

  // Immediate and register indices by format
  always_comb begin : operands
    imm_d  = '0;
    regs_d = '0;
    case (instr[4:2])
      3'b000: begin
        case (instr[6:5])
          2'b00: begin  // LOAD
            imm_d       = {{20{instr[31]}}, instr[31:20]};
            regs_d.rd   = instr[11:7];
            regs_d.rs_1 = instr[19:15];
          end
          2'b01: begin  // STORE
            imm_d       = {{20{instr[31]}}, instr[31:25], instr[11:7]};
            regs_d.rs_1 = instr[19:15];
            regs_d.rs_2 = instr[24:20];
          end
          2'b11: begin  // BRANCH
            imm_d       = {{20{instr[31]}}, instr[7], instr[30:25], instr[11:8], 1'b0};
            regs_d.rs_1 = instr[19:15];
            regs_d.rs_2 = instr[24:20];
          end
        endcase
      end
      3'b001: begin
        if (instr[6:5] == 2'b11) begin  // JALR
          imm_d       = {{20{instr[31]}}, instr[31:20]};
          regs_d.rd   = instr[11:7];
          regs_d.rs_1 = instr[19:15];
        end
      end
      3'b011: begin
        if (instr[6:5] == 2'b11) begin  // JAL
          imm_d     = {{12{instr[31]}}, instr[19:12], instr[20], instr[30:21], 1'b0};
          regs_d.rd = instr[11:7];
        end
      end
      3'b100: begin
        case (instr[6:5])
          2'b00: begin  // OP-IMM
            if (funct3 == 3'b001 || funct3 == 3'b101) imm_d = {27'd0, instr[24:20]};
            else imm_d = {{20{instr[31]}}, instr[31:20]};
            regs_d.rd   = instr[11:7];
            regs_d.rs_1 = instr[19:15];
          end
          2'b01: begin  // OP
            regs_d.rd   = instr[11:7];
            regs_d.rs_1 = instr[19:15];
            regs_d.rs_2 = instr[24:20];
          end
        endcase
      end
      3'b101: begin
        if (!instr[6]) begin  // LUI, AUIPC
          imm_d     = {instr[31:12], 12'd0};
          regs_d.rd = instr[11:7];
        end
      end
    endcase
  end

  // Mnemonic, class and flags, cleared for every word
  always_comb begin : naming
    name_d  = UNKNOWN;
    type_d  = AL;
    flags_d = '0;
    if (instr != 32'h0) begin
      case (instr[4:2])
        3'b000: begin
          case (instr[6:5])
            2'b00: begin  // LOAD
              flags_d.writes = 1'b1;
              type_d         = LS;
              case (funct3)
                3'b000: name_d = LB;
                3'b001: name_d = LH;
                3'b010: name_d = LW;
                3'b100: name_d = LBU;
                3'b101: name_d = LHU;
              endcase
            end
            2'b01: begin  // STORE
              type_d = LS;
              case (funct3)
                3'b000: name_d = SB;
                3'b001: name_d = SH;
                3'b010: name_d = SW;
              endcase
            end
            2'b11: begin  // BRANCH
              flags_d.jumps = 1'b1;
              type_d        = BR;
              case (funct3)
                3'b000: name_d = BEQ;
                3'b001: name_d = BNE;
                3'b100: name_d = BLT;
                3'b101: name_d = BGE;
                3'b110: name_d = BLTU;
                3'b111: name_d = BGEU;
              endcase
            end
          endcase
        end
        3'b001: begin
          if (instr[6:5] == 2'b11) begin
            flags_d.writes = 1'b1;
            flags_d.jumps  = 1'b1;
            type_d         = BR;
            name_d         = JALR;
          end
        end
        3'b011: begin
          if (instr[6:5] == 2'b00) begin
            name_d = ADDI;  // FENCE
          end else if (instr[6:5] == 2'b11) begin
            flags_d.writes = 1'b1;
            flags_d.jumps  = 1'b1;
            type_d         = BR;
            name_d         = JAL;
          end
        end
        3'b100: begin
          case (instr[6:5])
            2'b00: begin  // OP-IMM
              flags_d.writes   = 1'b1;
              flags_d.uses_imm = 1'b1;
              case (funct3)
                3'b000: name_d = ADDI;
                3'b001: name_d = SLLI;
                3'b010: name_d = SLTI;
                3'b011: name_d = SLTIU;
                3'b100: name_d = XORI;
                3'b101: name_d = funct7[5] ? SRAI : SRLI;
                3'b110: name_d = ORI;
                3'b111: name_d = ANDI;
              endcase
            end
            2'b01: begin  // OP
              flags_d.writes = 1'b1;
              case (funct3)
                3'b000: name_d = funct7[5] ? SUB : ADD;
                3'b001: name_d = SLL;
                3'b010: name_d = SLT;
                3'b011: name_d = SLTU;
                3'b100: name_d = XOR;
                3'b101: name_d = funct7[5] ? SRA : SRL;
                3'b110: name_d = OR;
                3'b111: name_d = AND;
              endcase
            end
            2'b11: name_d = instr[21] ? EBREAK : ECALL;
          endcase
        end
        3'b101: begin
          if (!instr[6]) begin
            flags_d.writes = 1'b1;
            name_d         = instr[5] ? LUI : AUIPC;
          end
        end
      endcase
    end
  end

  always_ff @(posedge global_bus or negedge arst_n) begin
    if (!arst_n) info_valid <= 1'b0;
    else info_valid <= in_valid && !stop && !flush;  // One pulse per record
  end

  always_ff @(posedge global_bus) begin
    if (in_valid && !stop) begin
      info <= '{address: in_pair.address, instr: instr, immediate: imm_d,
                instr_name: name_d, instr_type: type_d, flags: flags_d, regs: regs_d};
    end
  end

endmodule

`default_nettype wire

/* frontend_regs.sv */
// Control, boot address and delivered/unknown counters behind a write and read port
`timescale 1ns/1ps
`default_nettype none

`include "rv_frontend_defines.svh"

module frontend_regs import frontend_pkg::*; (
  input  logic              global_bus,
  input  logic              arst_n,
  input  logic              cfg_we,
  input  logic [`CFG_AW-1:0] cfg_addr,
  input  logic [`XLEN-1:0]  cfg_wdata,
  output logic [`XLEN-1:0]  cfg_rdata,
  output logic              enable,
  output logic              restart,
  output logic [`XLEN-1:0]  boot_addr,
  input  logic              deliver,
  input  logic              deliver_unknown
);
  logic [`CNT_W-1:0] decoded_cnt;
  logic [`CNT_W-1:0] unknown_cnt;

  always_ff @(posedge global_bus or negedge arst_n) begin
    if (!arst_n) begin
      enable      <= 1'b0;
      restart     <= 1'b0;
      boot_addr   <= `BOOT_ADDR_RESET;
      decoded_cnt <= '0;
      unknown_cnt <= '0;
    end else begin
      restart <= cfg_we && (cfg_addr == BOOT);  // Fetch sees the new address
      if (cfg_we && cfg_addr == CTRL) enable <= cfg_wdata[0];
      if (cfg_we && cfg_addr == BOOT) boot_addr <= cfg_wdata;
      if (deliver) decoded_cnt <= decoded_cnt + 1'b1;
      if (deliver_unknown) unknown_cnt <= unknown_cnt + 1'b1;
    end
  end

  always_comb begin
    case (cfg_addr)
      CTRL:        cfg_rdata = {{(`XLEN-1){1'b0}}, enable};
      BOOT:        cfg_rdata = boot_addr;
      DECODED_CNT: cfg_rdata = {{(`XLEN-`CNT_W){1'b0}}, decoded_cnt};
      UNKNOWN_CNT: cfg_rdata = {{(`XLEN-`CNT_W){1'b0}}, unknown_cnt};
      default:     cfg_rdata = '0;
    endcase
  end

endmodule

`default_nettype wire

/* rv_frontend.sv */
// Front end top with fetch unit, two skid buffers, decoder and register block
`timescale 1ns/1ps
`default_nettype none

`include "rv_frontend_defines.svh"

module rv_frontend import isa_pkg::*, frontend_pkg::*; (
  input  logic               global_bus,
  input  logic               arst_n,
  output logic               imem_req,
  output logic [`XLEN-1:0]   imem_addr,
  input  logic [31:0]        imem_rdata,
  input  logic               cfg_we,
  input  logic [`CFG_AW-1:0] cfg_addr,
  input  logic [`XLEN-1:0]   cfg_wdata,
  output logic [`XLEN-1:0]   cfg_rdata,
  input  logic               stop,
  output logic               out_valid,
  output logic [`XLEN-1:0]   out_address,
  output logic [31:0]        out_instr,
  output logic [`XLEN-1:0]   out_immediate,
  output instr_name_e        out_name,
  output instr_type_e        out_type,
  output instr_flags_t       out_flags,
  output reg_idx_t           out_regs
);
  logic             enable, restart, redirect, flush;
  logic [`XLEN-1:0] boot_addr, redirect_target;
  logic             fetch_valid, fetch_stop, buf_valid, dec_valid, dec_stop;
  fetch_pair_t      fetch_pair, buf_pair;
  instr_info_t      dec_info, out_rec;
  logic             deliver;

  // JAL target needs no register value
  assign redirect        = dec_valid && (dec_info.instr_name == JAL);
  assign redirect_target = dec_info.address + dec_info.immediate;
  assign flush           = redirect || restart;
  assign deliver         = out_valid && !stop;

  fetch_unit u_fetch (
    .global_bus, .arst_n, .enable, .restart, .boot_addr, .redirect, .redirect_target,
    .stop(fetch_stop), .imem_req, .imem_addr, .imem_rdata,
    .pair_valid(fetch_valid), .pair(fetch_pair)
  );

  skid_buffer #(.payload_t(fetch_pair_t)) u_fetch_buf (
    .global_bus, .arst_n, .flush, .in_valid(fetch_valid), .in_data(fetch_pair),
    .stop(fetch_stop), .out_valid(buf_valid), .out_data(buf_pair), .out_stop(dec_stop)
  );

  decoder u_decoder (
    .global_bus, .arst_n, .in_valid(buf_valid), .in_pair(buf_pair), .stop(dec_stop),
    .flush, .info_valid(dec_valid), .info(dec_info)
  );

  skid_buffer #(.payload_t(instr_info_t)) u_out_buf (
    .global_bus, .arst_n, .flush(1'b0), .in_valid(dec_valid), .in_data(dec_info),
    .stop(dec_stop), .out_valid, .out_data(out_rec), .out_stop(stop)
  );

  frontend_regs u_regs (
    .global_bus, .arst_n, .cfg_we, .cfg_addr, .cfg_wdata, .cfg_rdata,
    .enable, .restart, .boot_addr,
    .deliver, .deliver_unknown(deliver && out_rec.instr_name == UNKNOWN)
  );

  assign out_address   = out_rec.address;
  assign out_instr     = out_rec.instr;
  assign out_immediate = out_rec.immediate;
  assign out_name      = out_rec.instr_name;
  assign out_type      = out_rec.instr_type;
  assign out_flags     = out_rec.flags;
  assign out_regs      = out_rec.regs;

endmodule

`default_nettype wire

/* rv_frontend_sva.sv */
// Bound checker with reference RV32I decode rules and front end assertions
`timescale 1ns/1ps
`default_nettype none

`include "rv_frontend_defines.svh"

module rv_frontend_sva import isa_pkg::*; (
  input logic               global_bus,
  input logic               arst_n,
  input logic               enable,
  input logic               restart,
  input logic [`XLEN-1:0]   boot_addr,
  input logic               imem_req,
  input logic               stop,
  input logic               out_valid,
  input logic [`XLEN-1:0]   out_address,
  input logic [31:0]        out_instr,
  input logic [`XLEN-1:0]   out_immediate,
  input instr_name_e        out_name,
  input instr_type_e        out_type,
  input instr_flags_t       out_flags,
  input reg_idx_t           out_regs
);
  int               fails = 0;
  logic             ever_enabled;
  logic             have_next;
  logic [`XLEN-1:0] next_addr;
  instr_info_t      exp;

  function automatic instr_info_t expect_decode(input logic [31:0] w);
    instr_info_t r;
    logic [31:0] imm_i;
    r            = '0;
    r.instr_type = AL;
    r.instr_name = UNKNOWN;
    imm_i        = {{20{w[31]}}, w[31:20]};
    if (w == 32'd0) return r;
    case ({w[6:5], w[4:2]})
      5'b00_000: begin  // LOAD
        r.instr_type = LS;
        r.flags      = 3'b100;
        r.immediate  = imm_i;
        r.regs       = {w[11:7], w[19:15], 5'd0};
        case (w[14:12])
          3'd0: r.instr_name = LB;
          3'd1: r.instr_name = LH;
          3'd2: r.instr_name = LW;
          3'd4: r.instr_name = LBU;
          3'd5: r.instr_name = LHU;
          default: r.instr_name = UNKNOWN;
        endcase
      end
      5'b01_000: begin  // STORE
        r.instr_type = LS;
        r.immediate  = {{20{w[31]}}, w[31:25], w[11:7]};
        r.regs       = {5'd0, w[19:15], w[24:20]};
        case (w[14:12])
          3'd0: r.instr_name = SB;
          3'd1: r.instr_name = SH;
          3'd2: r.instr_name = SW;
          default: r.instr_name = UNKNOWN;
        endcase
      end
      5'b11_000: begin  // BRANCH
        r.instr_type = BR;
        r.flags      = 3'b010;
        r.immediate  = {{20{w[31]}}, w[7], w[30:25], w[11:8], 1'b0};
        r.regs       = {5'd0, w[19:15], w[24:20]};
        case (w[14:12])
          3'd0: r.instr_name = BEQ;
          3'd1: r.instr_name = BNE;
          3'd4: r.instr_name = BLT;
          3'd5: r.instr_name = BGE;
          3'd6: r.instr_name = BLTU;
          3'd7: r.instr_name = BGEU;
          default: r.instr_name = UNKNOWN;
        endcase
      end
      5'b11_001: begin
        r.instr_type = BR;
        r.flags      = 3'b110;
        r.immediate  = imm_i;
        r.regs       = {w[11:7], w[19:15], 5'd0};
        r.instr_name = JALR;
      end
      5'b11_011: begin
        r.instr_type = BR;
        r.flags      = 3'b110;
        r.immediate  = {{12{w[31]}}, w[19:12], w[20], w[30:21], 1'b0};
        r.regs       = {w[11:7], 10'd0};
        r.instr_name = JAL;
      end
      5'b00_011: r.instr_name = ADDI;  // FENCE
      5'b00_100: begin  // OP-IMM
        r.flags     = 3'b101;
        r.regs      = {w[11:7], w[19:15], 5'd0};
        r.immediate = (w[14:12] == 3'd1 || w[14:12] == 3'd5) ? {27'd0, w[24:20]} : imm_i;
        case (w[14:12])
          3'd0: r.instr_name = ADDI;
          3'd1: r.instr_name = SLLI;
          3'd2: r.instr_name = SLTI;
          3'd3: r.instr_name = SLTIU;
          3'd4: r.instr_name = XORI;
          3'd5: r.instr_name = w[30] ? SRAI : SRLI;
          3'd6: r.instr_name = ORI;
          default: r.instr_name = ANDI;
        endcase
      end
      5'b01_100: begin  // OP
        r.flags = 3'b100;
        r.regs  = {w[11:7], w[19:15], w[24:20]};
        case (w[14:12])
          3'd0: r.instr_name = w[30] ? SUB : ADD;
          3'd1: r.instr_name = SLL;
          3'd2: r.instr_name = SLT;
          3'd3: r.instr_name = SLTU;
          3'd4: r.instr_name = XOR;
          3'd5: r.instr_name = w[30] ? SRA : SRL;
          3'd6: r.instr_name = OR;
          default: r.instr_name = AND;
        endcase
      end
      5'b11_100: r.instr_name = w[21] ? EBREAK : ECALL;
      5'b01_101, 5'b00_101: begin
        r.flags      = 3'b100;
        r.immediate  = {w[31:12], 12'd0};
        r.regs       = {w[11:7], 10'd0};
        r.instr_name = w[5] ? LUI : AUIPC;
      end
      default: r.instr_name = UNKNOWN;
    endcase
    return r;
  endfunction

  always_comb exp = expect_decode(out_instr);

  // Expected address of the next delivered record
  always_ff @(posedge global_bus or negedge arst_n) begin
    if (!arst_n) begin
      ever_enabled <= 1'b0;
      have_next    <= 1'b0;
      next_addr    <= '0;
    end else begin
      if (enable) ever_enabled <= 1'b1;
      if (restart) begin
        have_next <= 1'b1;
        next_addr <= boot_addr;
      end else if (out_valid && !stop) begin
        have_next <= 1'b1;
        next_addr <= (exp.instr_name == JAL) ? out_address + exp.immediate : out_address + 32'd4;
      end
    end
  end

  a_idle: assert property (@(posedge global_bus) disable iff (!arst_n)
    !(ever_enabled || enable) |-> !imem_req && !out_valid)
    else begin
      fails++;
      $error("fetch or output active before enable");
    end

  a_name: assert property (@(posedge global_bus) disable iff (!arst_n)
    out_valid |-> out_name == exp.instr_name)
    else begin
      fails++;
      $error("FAILED out_name %h expected %h", out_name, exp.instr_name);
    end

  a_type: assert property (@(posedge global_bus) disable iff (!arst_n)
    out_valid |-> out_type == exp.instr_type)
    else begin
      fails++;
      $error("FAILED out_type %h expected %h", out_type, exp.instr_type);
    end

  a_flags: assert property (@(posedge global_bus) disable iff (!arst_n)
    out_valid |-> out_flags == exp.flags)
    else begin
      fails++;
      $error("FAILED out_flags %h expected %h", out_flags, exp.flags);
    end

  a_regs: assert property (@(posedge global_bus) disable iff (!arst_n)
    out_valid |-> out_regs == exp.regs)
    else begin
      fails++;
      $error("FAILED out_regs %h expected %h", out_regs, exp.regs);
    end

  a_imm: assert property (@(posedge global_bus) disable iff (!arst_n)
    out_valid |-> out_immediate == exp.immediate)
    else begin
      fails++;
      $error("FAILED out_immediate %h expected %h", out_immediate, exp.immediate);
    end

  a_hold: assert property (@(posedge global_bus) disable iff (!arst_n)
    out_valid && stop |=> out_valid && $stable(out_address) && $stable(out_instr) &&
                          $stable(out_immediate) && $stable(out_name) && $stable(out_type) &&
                          $stable(out_flags) && $stable(out_regs))
    else begin
      fails++;
      $error("record changed while stopped");
    end

  a_addr: assert property (@(posedge global_bus) disable iff (!arst_n)
    out_valid && have_next |-> out_address == next_addr)
    else begin
      fails++;
      $error("FAILED out_address %h expected %h", out_address, next_addr);
    end

endmodule

bind rv_frontend rv_frontend_sva chk (.*);

`default_nettype wire

/* tb_clock_gen.sv */
// Testbench clock and reset generator
`timescale 1ns/1ps
`default_nettype none

module tb_clock_gen (
  output logic global_bus,
  output logic arst_n
);
  initial begin
    global_bus = 1'b0;
    forever #20 global_bus = ~global_bus;  // 40 ns period
  end

  initial begin
    arst_n = 1'b0;
    repeat (10) @(posedge global_bus);
    arst_n <= 1'b1;
  end

endmodule

`default_nettype wire

/* tb_rv_frontend.sv */
// Front end testbench with memory model, LFSR program, stop stimulus and reporting
`timescale 1ns/1ps
`default_nettype none

`include "rv_frontend_defines.svh"

module tb_rv_frontend import isa_pkg::*, frontend_pkg::*;;
  localparam int N_RECORDS       = 400;
  localparam int WATCHDOG_CYCLES = N_RECORDS * 8 + 400;
  localparam logic [31:0] BOOT_TARGET = 32'h0000_0200;

  logic               global_bus, arst_n;
  logic               imem_req, cfg_we, stop, out_valid;
  logic [`XLEN-1:0]   imem_addr, cfg_wdata, cfg_rdata, out_address, out_immediate;
  logic [31:0]        imem_rdata, out_instr, got;
  logic [`CFG_AW-1:0] cfg_addr;
  instr_name_e        out_name;
  instr_type_e        out_type;
  instr_flags_t       out_flags;
  reg_idx_t           out_regs;
  logic [31:0]        mem [0:1023];
  logic [31:0]        lfsr = 32'h7046;
  int                 delivered = 0;
  int                 unknown = 0;
  int                 errors = 0;
  int                 quiet;

  tb_clock_gen clk_gen (.global_bus, .arst_n);

  rv_frontend uut (.*);

  function automatic logic [31:0] rand_bits(input int n);
    logic [31:0] v;
    v = '0;
    for (int i = 0; i < n; i++) begin
      lfsr = {lfsr[30:0], lfsr[31] ^ lfsr[21] ^ lfsr[1] ^ lfsr[0]};
      v    = {v[30:0], lfsr[0]};
    end
    return v;
  endfunction

  task automatic build_program();
    logic [31:0] r, w, off;
    logic [3:0]  sel;
    for (int a = 0; a < 1024; a++) begin
      r   = rand_bits(32);
      sel = 4'(rand_bits(4));
      case (sel)
        4'd0:        w = 32'd0;
        4'd1, 4'd15: w = {r[31:7], 7'b0000011};
        4'd2:        w = {r[31:7], 7'b0100011};
        4'd3:        w = {r[31:7], 7'b1100011};
        4'd4:        w = {r[31:7], 7'b1100111};
        4'd5: begin
          off = (rand_bits(3) + 32'd1) * 32'd4;  // Short forward JAL
          w   = {1'b0, off[10:1], 1'b0, 8'd0, r[11:7], 7'b1101111};
        end
        4'd6, 4'd12: w = {r[31:7], 7'b0010011};
        4'd7, 4'd13: w = {r[31:7], 7'b0110011};
        4'd8:        w = {r[31:7], 7'b0110111};
        4'd9:        w = {r[31:7], 7'b0010111};
        4'd10:       w = {r[31:7], 7'b0001111};
        4'd11:       w = {r[31:7], 7'b1110011};
        default:     w = r;
      endcase
      mem[a] = w;
    end
  endtask

  task automatic write_cfg(input cfg_addr_e addr, input logic [31:0] data);
    @(posedge global_bus);
    cfg_we    <= 1'b1;
    cfg_addr  <= addr;
    cfg_wdata <= data;
    @(posedge global_bus);
    cfg_we    <= 1'b0;
  endtask

  task automatic read_cfg(input cfg_addr_e addr, output logic [31:0] data);
    @(posedge global_bus);
    cfg_addr <= addr;
    @(negedge global_bus);
    data = cfg_rdata;
  endtask

  task automatic report(input string name);
    $display("test %s finished, %0d errors so far", name, errors + uut.chk.fails);
  endtask

  always @(posedge global_bus) begin
    if (imem_req) imem_rdata <= mem[imem_addr[11:2]];  // One cycle latency
  end

  always @(posedge global_bus) begin
    if (arst_n && out_valid) begin
      assert (out_instr == mem[out_address[11:2]]) else begin
        errors++;
        $display("FAILED out_instr %h expected %h", out_instr, mem[out_address[11:2]]);
      end
    end
    if (arst_n && out_valid && !stop) begin
      delivered++;
      if (uut.chk.exp.instr_name == UNKNOWN) unknown++;
    end
  end

  initial begin
    #(WATCHDOG_CYCLES * 40);
    $display("watchdog expired before the tests completed");
    $display("tests failed");
    $finish;
  end

  initial begin
    stop       = 1'b0;
    cfg_we     = 1'b0;
    cfg_addr   = '0;
    cfg_wdata  = '0;
    imem_rdata = '0;
    build_program();
    wait (arst_n);
    repeat (20) @(posedge global_bus);
    report("idle_after_reset");

    write_cfg(BOOT, BOOT_TARGET);
    write_cfg(CTRL, 32'd1);
    while (delivered < N_RECORDS) begin
      @(posedge global_bus);
      stop <= (rand_bits(2) == 32'd0);
      @(negedge global_bus);
    end
    report("decode_address_back_pressure");

    @(posedge global_bus);
    stop <= 1'b0;
    write_cfg(CTRL, 32'd0);
    quiet = 0;
    while (quiet < 8) begin
      @(posedge global_bus);
      quiet = out_valid ? 0 : quiet + 1;
    end
    report("drain");

    read_cfg(DECODED_CNT, got);
    assert (got == 32'(delivered)) else begin
      $display("FAILED DECODED_CNT got %h expected %h", got, 32'(delivered));
      errors++;
    end
    read_cfg(UNKNOWN_CNT, got);
    assert (got == 32'(unknown)) else begin
      $display("FAILED UNKNOWN_CNT got %h expected %h", got, 32'(unknown));
      errors++;
    end
    report("counters");

    $display("records %0d, unknown %0d, errors %0d", delivered, unknown,
             errors + uut.chk.fails);
    if (errors + uut.chk.fails == 0) begin
      $display("all tests passed");
    end else begin
      $display("tests failed");
    end
    $finish;
  end

endmodule

`default_nettype wire

/* rv_frontend.f */
+incdir+.
isa_pkg.sv
frontend_pkg.sv
fetch_unit.sv
skid_buffer.sv
decoder.sv
frontend_regs.sv
rv_frontend.sv
rv_frontend_sva.sv
tb_clock_gen.sv
tb_rv_frontend.sv

/* run_sim.sh */
#!/bin/sh
# Builds the front end testbench with Verilator and runs it

cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert -Wno-fatal --top-module tb_rv_frontend \
  -f rv_frontend.f --Mdir obj_dir -o sim_rv_frontend
if [ $? -ne 0 ]; then
  echo "Verilator build failed"
  exit 1
fi

./obj_dir/sim_rv_frontend +verilator+error+limit+1000 > sim.log 2>&1
status=$?
cat sim.log
if [ $status -ne 0 ]; then
  echo "simulation exited with status $status"
  exit 1
fi

if grep -q "tests failed" sim.log; then
  exit 1
fi
exit 0
